//--- hdl/tap_pkg.sv
// TAP controller package
// Shared widths, instruction codes, TAP states and the packed
// structs that carry control and DMI chain signals between blocks

package tap_pkg;

    // ------------------------------
    // Widths and value types
    // ------------------------------
    localparam int TAP_IR_WIDTH     = 5;
    localparam int TAP_IDCODE_WIDTH = 32;
    localparam int TAP_BLD_ID_WIDTH = 32;

    typedef logic [TAP_IR_WIDTH-1:0]     tap_instr_t;
    typedef logic [TAP_IDCODE_WIDTH-1:0] tap_idcode_t;
    typedef logic [TAP_BLD_ID_WIDTH-1:0] tap_bld_id_t;
    typedef logic [1:0]                  dmi_ch_id_t;

    // Instruction codes, unlisted codes fall back to BYPASS
    localparam tap_instr_t TAP_INSTR_IDCODE     = 5'h01;
    localparam tap_instr_t TAP_INSTR_BLD_ID     = 5'h04;
    localparam tap_instr_t TAP_INSTR_DTMCS      = 5'h10;
    localparam tap_instr_t TAP_INSTR_DMI_ACCESS = 5'h11;
    localparam tap_instr_t TAP_INSTR_BYPASS     = 5'h1F;

    // Fixed build identifier
    localparam tap_bld_id_t TAP_BLD_ID_VALUE = 32'h2109_0800;

    // DMI chain identifiers
    localparam dmi_ch_id_t DMI_CH_ID_NONE  = 2'd0;
    localparam dmi_ch_id_t DMI_CH_ID_DTMCS = 2'd1;
    localparam dmi_ch_id_t DMI_CH_ID_DMI   = 2'd2;

    // ------------------------------
    // TAP state machine
    // ------------------------------
    typedef enum logic [3:0] {
        TAP_STATE_RESET       = 4'd0,
        TAP_STATE_IDLE        = 4'd1,
        TAP_STATE_DR_SEL_SCAN = 4'd2,
        TAP_STATE_DR_CAPTURE  = 4'd3,
        TAP_STATE_DR_SHIFT    = 4'd4,
        TAP_STATE_DR_EXIT1    = 4'd5,
        TAP_STATE_DR_PAUSE    = 4'd6,
        TAP_STATE_DR_EXIT2    = 4'd7,
        TAP_STATE_DR_UPDATE   = 4'd8,
        TAP_STATE_IR_SEL_SCAN = 4'd9,
        TAP_STATE_IR_CAPTURE  = 4'd10,
        TAP_STATE_IR_SHIFT    = 4'd11,
        TAP_STATE_IR_EXIT1    = 4'd12,
        TAP_STATE_IR_PAUSE    = 4'd13,
        TAP_STATE_IR_EXIT2    = 4'd14,
        TAP_STATE_IR_UPDATE   = 4'd15
    } tap_state_e;

    // ------------------------------
    // Control and chain bundles
    // ------------------------------
    // Control from the FSM, IR strobes combinational, DR strobes registered
    typedef struct packed {
        logic sync_rst_n;
        logic ir_capture;
        logic ir_shift;
        logic ir_update;
        logic dr_capture;
        logic dr_shift;
        logic dr_update;
    } tap_ctrl_t;

    // One-hot data register select
    typedef struct packed {
        logic bypass;
        logic idcode;
        logic bld_id;
        logic dmi;
    } tap_dr_sel_t;

    // Outputs towards the debug module
    typedef struct packed {
        logic       sel;
        dmi_ch_id_t ch_id;
        logic       capture;
        logic       shift;
        logic       update;
        logic       tdi;
    } dmi_chain_t;

endpackage : tap_pkg

//--- hdl/tap_fsm.sv
// TAP state machine
// 16-state IEEE 1149.1 controller, falling-edge synchronous reset
// and registered DR capture/shift/update strobes

`timescale 1ns/100ps

module tap_fsm (
    input  logic               tapc_tck,
    input  logic               tapc_trst_n,
    input  logic               tms_i,
    output tap_pkg::tap_ctrl_t ctrl_o
);

    import tap_pkg::*;

    tap_state_e state_q;
    tap_state_e state_next;

    logic sync_rst_n_q;
    logic dr_capture_q;
    logic dr_shift_q;
    logic dr_update_q;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            state_q <= TAP_STATE_RESET;
        end else begin
            state_q <= state_next;
        end
    end

    // Standard TAP transitions, TMS picks the branch
    always_comb begin
        case (state_q)
            TAP_STATE_RESET:       state_next = tms_i ? TAP_STATE_RESET       : TAP_STATE_IDLE;
            TAP_STATE_IDLE:        state_next = tms_i ? TAP_STATE_DR_SEL_SCAN : TAP_STATE_IDLE;
            TAP_STATE_DR_SEL_SCAN: state_next = tms_i ? TAP_STATE_IR_SEL_SCAN : TAP_STATE_DR_CAPTURE;
            TAP_STATE_DR_CAPTURE:  state_next = tms_i ? TAP_STATE_DR_EXIT1    : TAP_STATE_DR_SHIFT;
            TAP_STATE_DR_SHIFT:    state_next = tms_i ? TAP_STATE_DR_EXIT1    : TAP_STATE_DR_SHIFT;
            TAP_STATE_DR_EXIT1:    state_next = tms_i ? TAP_STATE_DR_UPDATE   : TAP_STATE_DR_PAUSE;
            TAP_STATE_DR_PAUSE:    state_next = tms_i ? TAP_STATE_DR_EXIT2    : TAP_STATE_DR_PAUSE;
            TAP_STATE_DR_EXIT2:    state_next = tms_i ? TAP_STATE_DR_UPDATE   : TAP_STATE_DR_SHIFT;
            TAP_STATE_DR_UPDATE:   state_next = tms_i ? TAP_STATE_DR_SEL_SCAN : TAP_STATE_IDLE;
            TAP_STATE_IR_SEL_SCAN: state_next = tms_i ? TAP_STATE_RESET       : TAP_STATE_IR_CAPTURE;
            TAP_STATE_IR_CAPTURE:  state_next = tms_i ? TAP_STATE_IR_EXIT1    : TAP_STATE_IR_SHIFT;
            TAP_STATE_IR_SHIFT:    state_next = tms_i ? TAP_STATE_IR_EXIT1    : TAP_STATE_IR_SHIFT;
            TAP_STATE_IR_EXIT1:    state_next = tms_i ? TAP_STATE_IR_UPDATE   : TAP_STATE_IR_PAUSE;
            TAP_STATE_IR_PAUSE:    state_next = tms_i ? TAP_STATE_IR_EXIT2    : TAP_STATE_IR_PAUSE;
            TAP_STATE_IR_EXIT2:    state_next = tms_i ? TAP_STATE_IR_UPDATE   : TAP_STATE_IR_SHIFT;
            TAP_STATE_IR_UPDATE:   state_next = tms_i ? TAP_STATE_DR_SEL_SCAN : TAP_STATE_IDLE;
            default:               state_next = TAP_STATE_RESET;
        endcase
    end

    // Sync reset, low while parked in Test-Logic-Reset
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            sync_rst_n_q <= 1'b0;
        end else begin
            sync_rst_n_q <= (state_q != TAP_STATE_RESET);
        end
    end

    // ------------------------------
    // DR strobes
    // ------------------------------
    // Taken from next state so they line up with state_q
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            dr_capture_q <= 1'b0;
            dr_shift_q   <= 1'b0;
            dr_update_q  <= 1'b0;
        end else if (!sync_rst_n_q) begin
            dr_capture_q <= 1'b0;
            dr_shift_q   <= 1'b0;
            dr_update_q  <= 1'b0;
        end else begin
            dr_capture_q <= (state_next == TAP_STATE_DR_CAPTURE);
            dr_shift_q   <= (state_next == TAP_STATE_DR_SHIFT);
            dr_update_q  <= (state_next == TAP_STATE_DR_UPDATE);
        end
    end

    // Control bundle out
    always_comb begin
        ctrl_o.sync_rst_n = sync_rst_n_q;
        ctrl_o.ir_capture = (state_q == TAP_STATE_IR_CAPTURE);
        ctrl_o.ir_shift   = (state_q == TAP_STATE_IR_SHIFT);
        ctrl_o.ir_update  = (state_q == TAP_STATE_IR_UPDATE);
        ctrl_o.dr_capture = dr_capture_q;
        ctrl_o.dr_shift   = dr_shift_q;
        ctrl_o.dr_update  = dr_update_q;
    end

endmodule : tap_fsm

//--- hdl/tap_ir.sv
// TAP instruction register
// Instruction shift register, falling-edge IR and the decoder that
// picks one data register and the DMI chain identifier

`timescale 1ns/100ps

module tap_ir (
    input  logic                 tapc_tck,
    input  logic                 tapc_trst_n,
    input  logic                 tdi_i,
    input  tap_pkg::tap_ctrl_t   ctrl_i,
    output logic                 ir_tdo_o,
    output tap_pkg::tap_dr_sel_t dr_sel_o,
    output tap_pkg::dmi_ch_id_t  ch_id_o
);

    import tap_pkg::*;

    tap_instr_t ir_shift_q;
    tap_instr_t ir_q;

    // Shift register, capture pattern is 1, TDI enters at the MSB
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_shift_q <= '0;
        end else if (!ctrl_i.sync_rst_n) begin
            ir_shift_q <= '0;
        end else if (ctrl_i.ir_capture) begin
            ir_shift_q <= tap_instr_t'(1);
        end else if (ctrl_i.ir_shift) begin
            ir_shift_q <= {tdi_i, ir_shift_q[TAP_IR_WIDTH-1:1]};
        end
    end

    assign ir_tdo_o = ir_shift_q[0];

    // IR proper, updated half a cycle into Update-IR
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            ir_q <= TAP_INSTR_IDCODE;
        end else if (!ctrl_i.sync_rst_n) begin
            ir_q <= TAP_INSTR_IDCODE;
        end else if (ctrl_i.ir_update) begin
            ir_q <= ir_shift_q;
        end
    end

    // ------------------------------
    // Decoder
    // ------------------------------
    always_comb begin
        dr_sel_o = '0;
        ch_id_o  = DMI_CH_ID_NONE;
        case (ir_q)
            TAP_INSTR_IDCODE: dr_sel_o.idcode = 1'b1;
            TAP_INSTR_BLD_ID: dr_sel_o.bld_id = 1'b1;
            TAP_INSTR_BYPASS: dr_sel_o.bypass = 1'b1;
            TAP_INSTR_DTMCS: begin
                dr_sel_o.dmi = 1'b1;
                ch_id_o      = DMI_CH_ID_DTMCS;
            end
            TAP_INSTR_DMI_ACCESS: begin
                dr_sel_o.dmi = 1'b1;
                ch_id_o      = DMI_CH_ID_DMI;
            end
            // Unknown codes behave as BYPASS
            default: dr_sel_o.bypass = 1'b1;
        endcase
    end

endmodule : tap_ir

//--- hdl/tap_data_regs.sv
// TAP data registers
// BYPASS, IDCODE and BUILD ID shift registers plus the serial
// read multiplexer, which also passes the DMI chain TDO through

`timescale 1ns/100ps

module tap_data_regs (
    input  logic                 tapc_tck,
    input  logic                 tapc_trst_n,
    input  logic                 tdi_i,
    input  tap_pkg::tap_ctrl_t   ctrl_i,
    input  tap_pkg::tap_dr_sel_t dr_sel_i,
    input  tap_pkg::tap_idcode_t idcode_i,
    input  logic                 ch_tdo_i,
    output logic                 dr_tdo_o
);

    import tap_pkg::*;

    logic        bypass_q;
    tap_idcode_t idcode_q;
    tap_bld_id_t bld_id_q;

    // ------------------------------
    // BYPASS
    // ------------------------------
    // Single stage, captures 0
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            bypass_q <= 1'b0;
        end else if (!ctrl_i.sync_rst_n) begin
            bypass_q <= 1'b0;
        end else if (dr_sel_i.bypass) begin
            if (ctrl_i.dr_capture) begin
                bypass_q <= 1'b0;
            end else if (ctrl_i.dr_shift) begin
                bypass_q <= tdi_i;
            end
        end
    end

    // ------------------------------
    // IDCODE
    // ------------------------------
    // Device ID from the fuse input
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            idcode_q <= '0;
        end else if (!ctrl_i.sync_rst_n) begin
            idcode_q <= '0;
        end else if (dr_sel_i.idcode) begin
            if (ctrl_i.dr_capture) begin
                idcode_q <= idcode_i;
            end else if (ctrl_i.dr_shift) begin
                idcode_q <= {tdi_i, idcode_q[TAP_IDCODE_WIDTH-1:1]};
            end
        end
    end

    // ------------------------------
    // BUILD ID
    // ------------------------------
    // Fixed build constant
    always_ff @(posedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            bld_id_q <= '0;
        end else if (!ctrl_i.sync_rst_n) begin
            bld_id_q <= '0;
        end else if (dr_sel_i.bld_id) begin
            if (ctrl_i.dr_capture) begin
                bld_id_q <= TAP_BLD_ID_VALUE;
            end else if (ctrl_i.dr_shift) begin
                bld_id_q <= {tdi_i, bld_id_q[TAP_BLD_ID_WIDTH-1:1]};
            end
        end
    end

    // Read mux, LSB of the selected register
    // DMI instructions hand the bit over from the debug module
    always_comb begin
        if (dr_sel_i.dmi) begin
            dr_tdo_o = ch_tdo_i;
        end else if (dr_sel_i.idcode) begin
            dr_tdo_o = idcode_q[0];
        end else if (dr_sel_i.bld_id) begin
            dr_tdo_o = bld_id_q[0];
        end else begin
            dr_tdo_o = bypass_q;
        end
    end

endmodule : tap_data_regs

//--- hdl/tap_tdo_drive.sv
// TAP TDO driver
// Falling-edge TDO and TDO enable, with IR or DR bit selected by
// the current shift state

`timescale 1ns/100ps

module tap_tdo_drive (
    input  logic               tapc_tck,
    input  logic               tapc_trst_n,
    input  tap_pkg::tap_ctrl_t ctrl_i,
    input  logic               dr_tdo_i,
    input  logic               ir_tdo_i,
    output logic               tdo_o,
    output logic               tdo_en_o
);

    logic tdo_next;
    logic tdo_en_next;

    // Enable only while shifting
    assign tdo_en_next = ctrl_i.dr_shift | ctrl_i.ir_shift;

    // DR bit has priority, idle output held at 0
    assign tdo_next = ctrl_i.dr_shift ? dr_tdo_i
                    : ctrl_i.ir_shift ? ir_tdo_i
                    : 1'b0;

    // Pin registers on the falling edge
    always_ff @(negedge tapc_tck or negedge tapc_trst_n) begin
        if (!tapc_trst_n) begin
            tdo_o    <= 1'b0;
            tdo_en_o <= 1'b0;
        end else if (!ctrl_i.sync_rst_n) begin
            tdo_o    <= 1'b0;
            tdo_en_o <= 1'b0;
        end else begin
            tdo_o    <= tdo_next;
            tdo_en_o <= tdo_en_next;
        end
    end

endmodule : tap_tdo_drive

//--- hdl/tap_ctrl_top.sv
// TAP controller top
// Connects the FSM, IR, data registers and TDO driver to the JTAG
// pins, the IDCODE fuses and the DMI scan chain

`timescale 1ns/100ps

module tap_ctrl_top (
    input  logic                 tapc_tck,
    input  logic                 tapc_trst_n,
    input  logic                 tms_i,
    input  logic                 tdi_i,
    input  tap_pkg::tap_idcode_t idcode_i,
    input  logic                 ch_tdo_i,
    output logic                 tdo_o,
    output logic                 tdo_en_o,
    output tap_pkg::dmi_chain_t  chain_o
);

    import tap_pkg::*;

    tap_ctrl_t   ctrl;
    tap_dr_sel_t dr_sel;
    dmi_ch_id_t  ch_id;
    logic        ir_tdo;
    logic        dr_tdo;

    tap_fsm tap_fsm_i (
        .tapc_tck    (tapc_tck),
        .tapc_trst_n (tapc_trst_n),
        .tms_i       (tms_i),
        .ctrl_o      (ctrl)
    );

    tap_ir tap_ir_i (
        .tapc_tck    (tapc_tck),
        .tapc_trst_n (tapc_trst_n),
        .tdi_i       (tdi_i),
        .ctrl_i      (ctrl),
        .ir_tdo_o    (ir_tdo),
        .dr_sel_o    (dr_sel),
        .ch_id_o     (ch_id)
    );

    tap_data_regs tap_data_regs_i (
        .tapc_tck    (tapc_tck),
        .tapc_trst_n (tapc_trst_n),
        .tdi_i       (tdi_i),
        .ctrl_i      (ctrl),
        .dr_sel_i    (dr_sel),
        .idcode_i    (idcode_i),
        .ch_tdo_i    (ch_tdo_i),
        .dr_tdo_o    (dr_tdo)
    );

    tap_tdo_drive tap_tdo_drive_i (
        .tapc_tck    (tapc_tck),
        .tapc_trst_n (tapc_trst_n),
        .ctrl_i      (ctrl),
        .dr_tdo_i    (dr_tdo),
        .ir_tdo_i    (ir_tdo),
        .tdo_o       (tdo_o),
        .tdo_en_o    (tdo_en_o)
    );

    // DMI chain, strobes follow the DR states directly
    always_comb begin
        chain_o.sel     = dr_sel.dmi;
        chain_o.ch_id   = ch_id;
        chain_o.capture = ctrl.dr_capture;
        chain_o.shift   = ctrl.dr_shift;
        chain_o.update  = ctrl.dr_update;
        chain_o.tdi     = tdi_i;
    end

endmodule : tap_ctrl_top

//--- tests/tap_ctrl_asserts.sv
// TAP controller protocol assertions
// Bound into the top level, watches the DMI chain outputs and the
// TDO enable against the TAP state

`timescale 1ns/100ps

module tap_ctrl_asserts (
    input logic                tapc_tck,
    input logic                tapc_trst_n,
    input logic                tms_i,
    input logic                tdi_i,
    input logic                tdo_en_i,
    input tap_pkg::tap_state_e state_i,
    input tap_pkg::dmi_chain_t chain_i
);

    import tap_pkg::*;

    // ------------------------------
    // DMI chain
    // ------------------------------
    // At most one strobe per cycle
    strobe_excl: assert property (@(posedge tapc_tck) disable iff (!tapc_trst_n)
        $onehot0({chain_i.capture, chain_i.shift, chain_i.update}))
        else $error("DMI chain strobes active together");

    // Chain id only while selected
    sel_id_match: assert property (@(posedge tapc_tck) disable iff (!tapc_trst_n)
        (chain_i.ch_id != DMI_CH_ID_NONE) == chain_i.sel)
        else $error("DMI chain id and select disagree");

    // ------------------------------
    // TDO enable
    // ------------------------------
    // Off one falling edge after any state other than shift or Exit1
    tdo_en_off: assert property (@(negedge tapc_tck) disable iff (!tapc_trst_n)
        !(state_i inside {TAP_STATE_DR_SHIFT, TAP_STATE_DR_EXIT1,
                          TAP_STATE_IR_SHIFT, TAP_STATE_IR_EXIT1}) |=> !tdo_en_i)
        else $error("TDO enabled outside a shift state");

    // Pins always driven once out of reset
    pins_known: assert property (@(posedge tapc_tck) disable iff (!tapc_trst_n)
        !$isunknown({tms_i, tdi_i}))
        else $error("TMS or TDI unknown");

endmodule : tap_ctrl_asserts

bind tap_ctrl_top tap_ctrl_asserts tap_ctrl_asserts_i (
    .tapc_tck    (tapc_tck),
    .tapc_trst_n (tapc_trst_n),
    .tms_i       (tms_i),
    .tdi_i       (tdi_i),
    .tdo_en_i    (tdo_en_o),
    .state_i     (tap_fsm_i.state_q),
    .chain_i     (chain_o)
);

//--- tests/tap_ctrl_tb.sv
// TAP controller testbench
// Bit-bangs the JTAG pins through IR and DR scans, models the DMI
// chain and compares scanned words with the expected values

`timescale 1ns/100ps

module tap_ctrl_tb;

    import tap_pkg::*;

    localparam int CLK_PERIOD = 4;
    // About 25 scans of at most 45 cycles plus reset, with wide margin
    localparam int WATCHDOG_CYCLES = 4000;

    // Expected values
    localparam logic [31:0] FUSE_IDCODE = 32'h5A3C_E6B1;
    localparam logic [31:0] EXP_BLD_ID  = 32'h2109_0800;
    localparam logic [31:0] EXP_IR_CAPT = 32'h0000_0001;

    logic        tapc_tck = 1'b0;
    logic        tapc_trst_n;
    logic        tms_i;
    logic        tdi_i;
    tap_idcode_t idcode_i;
    logic        ch_tdo_i;
    logic        tdo_o;
    logic        tdo_en_o;
    dmi_chain_t  chain_o;

    integer      seed = 32'h0908e763;
    logic        chain_bits[$];
    logic [31:0] din;
    logic [31:0] dout;

    tap_ctrl_top tap_ctrl_top_i (
        .tapc_tck    (tapc_tck),
        .tapc_trst_n (tapc_trst_n),
        .tms_i       (tms_i),
        .tdi_i       (tdi_i),
        .idcode_i    (idcode_i),
        .ch_tdo_i    (ch_tdo_i),
        .tdo_o       (tdo_o),
        .tdo_en_o    (tdo_en_o),
        .chain_o     (chain_o)
    );

    always #(CLK_PERIOD / 2) tapc_tck = ~tapc_tck;

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_word(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            $display("FAILED at %0.1f ns: %s expected %h, got %h",
                     $realtime, name, exp_val, act_val);
            $display("Checks failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        check_word(name, {31'b0, exp_val}, {31'b0, act_val});
    endtask

    // ------------------------------
    // JTAG pin driving
    // ------------------------------
    // One TCK cycle, inputs set just after the rising edge
    task automatic tck_cycle(input logic tms, input logic tdi);
        tms_i = tms;
        tdi_i = tdi;
        @(posedge tapc_tck);
        #0.5;
    endtask

    // TMS sequence, applied LSB first
    task automatic walk_tms(input logic [7:0] seq, input int len);
        for (int i = 0; i < len; i++) begin
            tck_cycle(seq[i], 1'b0);
        end
    endtask

    // Debug module side, fresh random bit per shift cycle
    task automatic drive_chain_bit();
        if (chain_o.shift) begin
            ch_tdo_i = 1'($random(seed));
            chain_bits.push_back(ch_tdo_i);
        end
    endtask

    // Shift len bits LSB first, TDO taken half a cycle in
    task automatic shift_bits(input logic [31:0] data_in, input int len,
                              input logic exit_last, output logic [31:0] data_out);
        data_out = '0;
        for (int i = 0; i < len; i++) begin
            drive_chain_bit();
            tms_i = exit_last && (i == len - 1);
            tdi_i = data_in[i];
            @(negedge tapc_tck);
            #0.5;
            data_out[i] = tdo_o;
            check_bit("tdo_en_o", 1'b1, tdo_en_o);
            // Chain sees TDI as driven
            check_bit("chain_o.tdi", data_in[i], chain_o.tdi);
            @(posedge tapc_tck);
            #0.5;
        end
    endtask

    // Cycle outside shift, TDO disabled and low
    task automatic check_quiet(input logic tms);
        tms_i = tms;
        tdi_i = 1'b0;
        @(negedge tapc_tck);
        #0.5;
        check_bit("tdo_en_o", 1'b0, tdo_en_o);
        check_bit("tdo_o", 1'b0, tdo_o);
        @(posedge tapc_tck);
        #0.5;
    endtask

    // Idle to Shift-IR, load, back to Idle
    task automatic load_instr(input logic [4:0] instr);
        logic [31:0] captured;
        walk_tms(8'b0000_0011, 4);
        shift_bits({27'b0, instr}, 5, 1'b1, captured);
        check_word("ir capture", EXP_IR_CAPT, captured);
        tck_cycle(1'b1, 1'b0);
        check_quiet(1'b0);
        check_quiet(1'b0);
    endtask

    // Full DR scan from Idle, strobes checked on the way
    task automatic scan_dr(input logic [31:0] data_in, input int len,
                           output logic [31:0] data_out);
        walk_tms(8'b0000_0001, 2);
        check_bit("chain_o.capture", 1'b1, chain_o.capture);
        tck_cycle(1'b0, 1'b0);
        check_bit("chain_o.shift", 1'b1, chain_o.shift);
        shift_bits(data_in, len, 1'b1, data_out);
        tck_cycle(1'b1, 1'b0);
        check_bit("chain_o.update", 1'b1, chain_o.update);
        check_quiet(1'b0);
        check_quiet(1'b0);
    endtask

    // DMI scan, TDO must replay the chain model bits
    task automatic scan_chain(input string name);
        logic [31:0] data_in;
        logic [31:0] data_out;
        logic [31:0] model_word;
        data_in = $random(seed);
        chain_bits.delete();
        scan_dr(data_in, 32, data_out);
        check_word("chain model bit count", 32'd32, 32'(chain_bits.size()));
        for (int i = 0; i < 32; i++) begin
            model_word[i] = chain_bits[i];
        end
        check_word(name, model_word, data_out);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        tapc_trst_n = 1'b0;
        tms_i       = 1'b1;
        tdi_i       = 1'b0;
        ch_tdo_i    = 1'b0;
        idcode_i    = FUSE_IDCODE;
        repeat (16) @(posedge tapc_tck);
        #0.5;
        tapc_trst_n = 1'b1;
        tck_cycle(1'b1, 1'b0);
        // Test-Logic-Reset, pins and chain quiet
        check_bit("tdo_en_o", 1'b0, tdo_en_o);
        check_bit("tdo_o", 1'b0, tdo_o);
        check_word("chain_o", 32'h0, 32'(chain_o));
        tck_cycle(1'b0, 1'b0);

        // IDCODE straight out of reset
        din = $random(seed);
        scan_dr(din, 32, dout);
        check_word("idcode scan", FUSE_IDCODE, dout);
        check_bit("chain_o.sel", 1'b0, chain_o.sel);

        // Same scan split by a stay in Pause-DR
        walk_tms(8'b0000_0001, 3);
        shift_bits(32'h0, 16, 1'b1, dout);
        check_word("idcode low half", {16'h0, FUSE_IDCODE[15:0]}, dout);
        tck_cycle(1'b0, 1'b0);
        check_quiet(1'b0);
        check_quiet(1'b0);
        walk_tms(8'b0000_0001, 2);
        shift_bits(32'h0, 16, 1'b1, dout);
        check_word("idcode high half", {16'h0, FUSE_IDCODE[31:16]}, dout);
        tck_cycle(1'b1, 1'b0);
        check_quiet(1'b0);

        // BUILD ID
        load_instr(5'h04);
        din = $random(seed);
        scan_dr(din, 32, dout);
        check_word("build id scan", EXP_BLD_ID, dout);

        // Abandoned scan parked in Pause-DR, five TMS high back to reset
        walk_tms(8'b0000_0001, 3);
        shift_bits(32'h0, 8, 1'b1, dout);
        tck_cycle(1'b0, 1'b0);
        walk_tms(8'b0001_1111, 5);
        // Test-Logic-Reset again, TDO and strobes quiet
        check_bit("tdo_en_o", 1'b0, tdo_en_o);
        check_bit("tdo_o", 1'b0, tdo_o);
        check_word("chain_o strobes", 32'h0,
                   32'({chain_o.capture, chain_o.shift, chain_o.update}));
        tck_cycle(1'b0, 1'b0);
        scan_dr(din, 32, dout);
        check_word("idcode after tms reset", FUSE_IDCODE, dout);

        // BYPASS and an unused code, one bit of delay
        load_instr(5'h1F);
        din = $random(seed);
        scan_dr(din, 32, dout);
        check_word("bypass scan", {din[30:0], 1'b0}, dout);
        load_instr(5'h0A);
        din = $random(seed);
        scan_dr(din, 32, dout);
        check_word("unused code scan", {din[30:0], 1'b0}, dout);

        // DMI chains
        load_instr(5'h10);
        check_bit("chain_o.sel", 1'b1, chain_o.sel);
        check_word("chain_o.ch_id", 32'd1, 32'(chain_o.ch_id));
        scan_chain("dtmcs chain scan");
        load_instr(5'h11);
        check_bit("chain_o.sel", 1'b1, chain_o.sel);
        check_word("chain_o.ch_id", 32'd2, 32'(chain_o.ch_id));
        scan_chain("dmi access chain scan");

        // Back to IDCODE, chain deselected
        load_instr(5'h01);
        check_bit("chain_o.sel", 1'b0, chain_o.sel);
        check_word("chain_o.ch_id", 32'd0, 32'(chain_o.ch_id));
        scan_dr(din, 32, dout);
        check_word("idcode reload scan", FUSE_IDCODE, dout);

        $display("All checks passed");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: test sequence still running after %0d TCK cycles",
                 WATCHDOG_CYCLES);
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

endmodule : tap_ctrl_tb

//--- project.f
hdl/tap_pkg.sv
hdl/tap_fsm.sv
hdl/tap_ir.sv
hdl/tap_data_regs.sv
hdl/tap_tdo_drive.sv
hdl/tap_ctrl_top.sv
tests/tap_ctrl_asserts.sv
tests/tap_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the TAP controller testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tap_ctrl_tb \
		-f project.f -Mdir obj_dir -o tap_ctrl_sim
	./obj_dir/tap_ctrl_sim 2>&1 | tee sim.log
	@if grep -q "Checks failed" sim.log; then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" sim.log; then echo "TEST FAILED"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir sim.log
